// File: logic/pmtrdt_pkg.sv
/*
  Shared sizes, opcodes and payload types for the permute/reduce back end.
  Every design file imports this package; the queue, both units, the merge
  and the top level all exchange the uop and result structs defined here.
*/
`default_nettype none

package pmtrdt_pkg;

  // element and vector geometry
  localparam int sew        = 8;
  localparam int num_elem   = 8;
  localparam int vlen       = sew * num_elem;
  // index of one element inside a vector
  localparam int elem_idx_w = $clog2(num_elem);

  // rob tag and queue sizing
  localparam int rob_idx_w  = 4;
  localparam int rs_depth   = 4;

  // vd_len field, wide enough to hold num_elem
  localparam int len_w      = 4;

  // opcode, 3 bits
  typedef enum logic [2:0] {
    op_cmp_eq   = 3'd0,
    op_cmp_lt   = 3'd1,
    op_red_sum  = 3'd2,
    op_red_max  = 3'd3,
    op_red_or   = 3'd4,
    op_compress = 3'd5
  } pmtrdt_op_e;

  // vs1 seen two ways
  // elem view for compare and reduction, mask view for compress
  typedef union packed {
    logic [num_elem-1:0][sew-1:0] elem;
    struct packed {
      // upper bits unused in the mask view
      logic [vlen-num_elem-1:0] rsvd;
      logic [num_elem-1:0]      mask;
    } m;
  } vs1_u;

  // one micro-op as it sits in the queue
  typedef struct packed {
    logic [rob_idx_w-1:0] rob_idx;
    pmtrdt_op_e           op;
    vs1_u                 vs1;
    logic [vlen-1:0]      vs2;
  } pmtrdt_uop_t;

  // result toward the rob
  // vd_len is 8 for compares, 1 for reductions, kept count for compress
  typedef struct packed {
    logic [rob_idx_w-1:0] rob_idx;
    logic [vlen-1:0]      vd;
    logic [len_w-1:0]     vd_len;
  } pu2rob_t;

endpackage

`default_nettype wire

// File: logic/pmtrdt_res_if.sv
/*
  Result channel from one execution unit to the result merge.
  The unit drives the source modport, the merge the sink modport.
  A result moves on valid and ready; valid and payload hold until taken.
*/
`timescale 1ns/1ps
`default_nettype none

interface pmtrdt_res_if;
  import pmtrdt_pkg::*;

  // handshake
  logic                 valid;
  logic                 ready;
  // payload
  logic [rob_idx_w-1:0] rob_idx;
  logic [vlen-1:0]      vd;
  logic [len_w-1:0]     vd_len;

  // unit side
  modport source (output valid, output rob_idx, output vd, output vd_len, input ready);
  // merge side
  modport sink (input valid, input rob_idx, input vd, input vd_len, output ready);

endinterface

`default_nettype wire

// File: logic/pmtrdt_rs_queue.sv
/*
  Four-entry in-order reservation queue for vector uops.
  Push on in_valid and in_ready; the head is offered to the unit picked by
  its opcode class and popped on that unit's valid and ready.
  A blocked head holds back every entry behind it.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_rs_queue (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t  in_uop,
  output logic                     in_ready,
  output logic                     rdt_valid,
  output pmtrdt_pkg::pmtrdt_uop_t  rdt_uop,
  input  logic                     rdt_ready,
  output logic                     cpr_valid,
  output pmtrdt_pkg::pmtrdt_uop_t  cpr_uop,
  input  logic                     cpr_ready
);
  import pmtrdt_pkg::*;

  localparam int ptr_w = $clog2(rs_depth);
  localparam int cnt_w = $clog2(rs_depth + 1);

  // storage, no reset needed on payload
  pmtrdt_uop_t        mem [rs_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;

  pmtrdt_uop_t        head;
  logic               not_empty;
  logic               head_is_cpr;
  logic               push;
  logic               pop;

  assign head        = mem[rd_ptr];
  assign not_empty   = (count != '0);
  // class decode of the head opcode
  assign head_is_cpr = (head.op == op_compress);

  // not full
  assign in_ready  = (count != cnt_w'(rs_depth));

  // only one unit sees valid at a time
  assign rdt_valid = not_empty & ~head_is_cpr;
  assign cpr_valid = not_empty & head_is_cpr;
  assign rdt_uop   = head;
  assign cpr_uop   = head;

  assign push = in_valid & in_ready;
  assign pop  = (rdt_valid & rdt_ready) | (cpr_valid & cpr_ready);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_uop;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/pmtrdt_rdt_cmp_unit.sv
/*
  Two-stage compare and reduction unit.
  Stage one does the element compares or the first tree level of the
  reduction; stage two finishes the tree, folds in vs1 element 0 and
  forms vd. Results leave through a result channel in accept order.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_rdt_cmp_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t  uop,
  output logic                     uop_ready,
  pmtrdt_res_if.source             res
);
  import pmtrdt_pkg::*;

  // one step of the reduction operator
  function automatic logic [sew-1:0] red_op(input pmtrdt_op_e op,
                                            input logic [sew-1:0] a,
                                            input logic [sew-1:0] b);
    logic [sew-1:0] r;
    case (op)
      op_red_max: r = ($signed(a) > $signed(b)) ? a : b;
      op_red_or:  r = a | b;
      // sum wraps mod 256
      default:    r = a + b;
    endcase
    return r;
  endfunction

  logic [num_elem-1:0][sew-1:0]   vs2_e;
  logic [num_elem-1:0]            cmp_mask;
  logic [num_elem/2-1:0][sew-1:0] part;

  // stage one registers
  logic                           s1_valid;
  logic [rob_idx_w-1:0]           s1_rob_idx;
  pmtrdt_op_e                     s1_op;
  logic [sew-1:0]                 s1_acc;
  logic [num_elem-1:0]            s1_mask;
  logic [num_elem/2-1:0][sew-1:0] s1_part;

  logic                           s1_is_cmp;
  logic [sew-1:0]                 scalar;

  // stage two registers
  logic                           s2_valid;
  logic [rob_idx_w-1:0]           s2_rob_idx;
  logic [vlen-1:0]                s2_vd;
  logic [len_w-1:0]               s2_vd_len;

  logic                           s2_adv;
  logic                           s1_free;

  // stage two can load when empty or being drained
  assign s2_adv    = ~s2_valid | res.ready;
  assign s1_free   = ~s1_valid | s2_adv;
  assign uop_ready = s1_free;

  assign vs2_e = uop.vs2;

  always_comb begin
    for (int i = 0; i < num_elem; i++) begin
      // lt compares vs2 against vs1, signed
      if (uop.op == op_cmp_eq) begin
        cmp_mask[i] = (vs2_e[i] == uop.vs1.elem[i]);
      end else begin
        cmp_mask[i] = ($signed(vs2_e[i]) < $signed(uop.vs1.elem[i]));
      end
    end
    // first tree level, adjacent pairs
    for (int j = 0; j < num_elem / 2; j++) begin
      part[j] = red_op(uop.op, vs2_e[2*j], vs2_e[2*j+1]);
    end
  end

  // rest of the tree, then vs1 element 0
  assign scalar = red_op(s1_op, s1_acc,
                         red_op(s1_op, red_op(s1_op, s1_part[0], s1_part[1]),
                                       red_op(s1_op, s1_part[2], s1_part[3])));
  assign s1_is_cmp = (s1_op == op_cmp_eq) || (s1_op == op_cmp_lt);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid <= uop_valid;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_free && uop_valid) begin
      s1_rob_idx <= uop.rob_idx;
      s1_op      <= uop.op;
      s1_acc     <= uop.vs1.elem[0];
      s1_mask    <= cmp_mask;
      s1_part    <= part;
    end
    // mask or scalar lands in the low byte
    if (s2_adv && s1_valid) begin
      s2_rob_idx <= s1_rob_idx;
      s2_vd      <= {{(vlen-sew){1'b0}}, (s1_is_cmp ? s1_mask : scalar)};
      s2_vd_len  <= s1_is_cmp ? len_w'(num_elem) : len_w'(1);
    end
  end

  assign res.valid   = s2_valid;
  assign res.rob_idx = s2_rob_idx;
  assign res.vd      = s2_vd;
  assign res.vd_len  = s2_vd_len;

endmodule

`default_nettype wire

// File: logic/pmtrdt_compress_unit.sv
/*
  Two-stage compress unit.
  Stage one reads vs1 as a mask and registers the prefix count for each
  element; stage two packs the selected vs2 elements from element 0,
  zero-fills the rest and reports the kept count in vd_len.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_compress_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t  uop,
  output logic                     uop_ready,
  pmtrdt_res_if.source             res
);
  import pmtrdt_pkg::*;

  logic [num_elem-1:0][elem_idx_w-1:0] pfx;
  logic [len_w-1:0]                    total;

  // stage one registers
  logic                                s1_valid;
  logic [rob_idx_w-1:0]                s1_rob_idx;
  logic [num_elem-1:0]                 s1_sel;
  logic [num_elem-1:0][elem_idx_w-1:0] s1_pfx;
  logic [len_w-1:0]                    s1_total;
  logic [num_elem-1:0][sew-1:0]        s1_vs2;

  logic [num_elem-1:0][sew-1:0]        packed_vd;

  // stage two registers
  logic                                s2_valid;
  logic [rob_idx_w-1:0]                s2_rob_idx;
  logic [vlen-1:0]                     s2_vd;
  logic [len_w-1:0]                    s2_vd_len;

  logic                                s2_adv;
  logic                                s1_free;

  assign s2_adv    = ~s2_valid | res.ready;
  assign s1_free   = ~s1_valid | s2_adv;
  assign uop_ready = s1_free;

  // exclusive prefix popcount of the mask
  always_comb begin
    total = '0;
    for (int i = 0; i < num_elem; i++) begin
      pfx[i] = total[elem_idx_w-1:0];
      total  = total + len_w'(uop.vs1.m.mask[i]);
    end
  end

  // scatter selected elements to their packed slot
  always_comb begin
    packed_vd = '0;
    for (int i = 0; i < num_elem; i++) begin
      if (s1_sel[i]) begin
        packed_vd[s1_pfx[i]] = s1_vs2[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid <= uop_valid;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_free && uop_valid) begin
      s1_rob_idx <= uop.rob_idx;
      s1_sel     <= uop.vs1.m.mask;
      s1_pfx     <= pfx;
      s1_total   <= total;
      s1_vs2     <= uop.vs2;
    end
    if (s2_adv && s1_valid) begin
      s2_rob_idx <= s1_rob_idx;
      s2_vd      <= packed_vd;
      s2_vd_len  <= s1_total;
    end
  end

  assign res.valid   = s2_valid;
  assign res.rob_idx = s2_rob_idx;
  assign res.vd      = s2_vd;
  assign res.vd_len  = s2_vd_len;

endmodule

`default_nettype wire

// File: logic/pmtrdt_result_merge.sv
/*
  Round-robin merge of the two unit result channels onto one ROB port.
  rob_valid follows the unit valids combinationally; with both valid the
  unit not granted last wins. The grant pointer moves only on a completed
  ROB transfer, and starts out favoring the compare/reduction unit.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_result_merge (
  input  logic                 clk,
  input  logic                 rst,
  pmtrdt_res_if.sink           rdt,
  pmtrdt_res_if.sink           cpr,
  output logic                 rob_valid,
  output pmtrdt_pkg::pu2rob_t  rob_result,
  input  logic                 rob_ready
);
  import pmtrdt_pkg::*;

  // set when compress held the last grant
  logic last_cpr;
  logic grant_cpr;
  logic grant_rdt;

  // compress wins if alone or if rdt went last
  assign grant_cpr = cpr.valid & (~rdt.valid | ~last_cpr);
  assign grant_rdt = rdt.valid & ~grant_cpr;

  assign rob_valid = rdt.valid | cpr.valid;

  // steer the granted channel
  always_comb begin
    if (grant_cpr) begin
      rob_result.rob_idx = cpr.rob_idx;
      rob_result.vd      = cpr.vd;
      rob_result.vd_len  = cpr.vd_len;
    end else begin
      rob_result.rob_idx = rdt.rob_idx;
      rob_result.vd      = rdt.vd;
      rob_result.vd_len  = rdt.vd_len;
    end
  end

  // ready only to the winner
  assign rdt.ready = rob_ready & grant_rdt;
  assign cpr.ready = rob_ready & grant_cpr;

  // reset value hands the first tie to rdt
  always_ff @(posedge clk) begin
    if (rst) begin
      last_cpr <= 1'b1;
    end else if (rob_valid && rob_ready) begin
      last_cpr <= grant_cpr;
    end
  end

endmodule

`default_nettype wire

// File: logic/pmtrdt_top.sv
/*
  Top level of the vector permute and reduce subsystem.
  Uops enter on a valid/ready port into the reservation queue, run in the
  compare/reduction or compress unit, and leave on the ROB result port.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t  uop,
  output logic                     uop_ready,
  output logic                     rob_valid,
  output pmtrdt_pkg::pu2rob_t      rob_result,
  input  logic                     rob_ready
);
  import pmtrdt_pkg::*;

  // queue head toward each unit
  logic        rdt_valid;
  pmtrdt_uop_t rdt_uop;
  logic        rdt_ready;
  logic        cpr_valid;
  pmtrdt_uop_t cpr_uop;
  logic        cpr_ready;

  // unit result channels
  pmtrdt_res_if rdt_res ();
  pmtrdt_res_if cpr_res ();

  pmtrdt_rs_queue u_rs_queue (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (uop_valid),
    .in_uop    (uop),
    .in_ready  (uop_ready),
    .rdt_valid (rdt_valid),
    .rdt_uop   (rdt_uop),
    .rdt_ready (rdt_ready),
    .cpr_valid (cpr_valid),
    .cpr_uop   (cpr_uop),
    .cpr_ready (cpr_ready)
  );

  pmtrdt_rdt_cmp_unit u_rdt_cmp (
    .clk       (clk),
    .rst       (rst),
    .uop_valid (rdt_valid),
    .uop       (rdt_uop),
    .uop_ready (rdt_ready),
    .res       (rdt_res.source)
  );

  pmtrdt_compress_unit u_compress (
    .clk       (clk),
    .rst       (rst),
    .uop_valid (cpr_valid),
    .uop       (cpr_uop),
    .uop_ready (cpr_ready),
    .res       (cpr_res.source)
  );

  pmtrdt_result_merge u_merge (
    .clk        (clk),
    .rst        (rst),
    .rdt        (rdt_res.sink),
    .cpr        (cpr_res.sink),
    .rob_valid  (rob_valid),
    .rob_result (rob_result),
    .rob_ready  (rob_ready)
  );

endmodule

`default_nettype wire

// File: tests/pmtrdt_tb.sv
/*
  Random-stimulus testbench for the permute/reduce back end.
  Issues random compare, reduction and compress uops with unique ROB tags,
  toggles rob_ready in random stretches, and checks every ROB transfer
  against a reference model kept per tag. Per-class issue order is tracked
  so results from one unit must come back in the order they went in.
*/
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_tb;
  import pmtrdt_pkg::*;

  localparam int clk_period = 40;
  localparam int num_uops   = 400;
  localparam int timeout_ns = (50 * num_uops + 200) * clk_period;
  localparam int seed_init  = 32'ha2d38ec0;

  logic        clk = 1'b0;
  logic        rst;
  logic        uop_valid;
  pmtrdt_uop_t uop;
  logic        uop_ready;
  logic        rob_valid;
  pu2rob_t     rob_result;
  logic        rob_ready;

  // separate streams for uops and back-pressure
  int          uop_seed = seed_init;
  int          bp_seed  = seed_init + 1;

  // scoreboard by tag
  pu2rob_t     exp_store [16];
  logic        outstanding [16];
  logic        is_cpr_tag [16];
  logic [3:0]  rdt_order [$];
  logic [3:0]  cpr_order [$];
  int          received = 0;
  logic        saw_full = 1'b0;
  logic        stalled = 1'b0;

  pmtrdt_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .uop_ready  (uop_ready),
    .rob_valid  (rob_valid),
    .rob_result (rob_result),
    .rob_ready  (rob_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  // reference model straight from the op definitions
  function automatic pu2rob_t expected_result(input pmtrdt_uop_t u);
    pu2rob_t     r;
    logic [63:0] v1;
    logic [7:0]  e1;
    logic [7:0]  e2;
    logic [7:0]  acc;
    int          k;
    v1 = u.vs1;
    r.rob_idx = u.rob_idx;
    r.vd = '0;
    r.vd_len = '0;
    acc = v1[7:0];
    k = 0;
    for (int i = 0; i < 8; i++) begin
      e1 = v1[8*i +: 8];
      e2 = u.vs2[8*i +: 8];
      case (u.op)
        op_cmp_eq:  r.vd[i] = (e2 == e1);
        op_cmp_lt:  r.vd[i] = ($signed(e2) < $signed(e1));
        op_red_sum: acc = acc + e2;
        op_red_max: acc = ($signed(e2) > $signed(acc)) ? e2 : acc;
        op_red_or:  acc = acc | e2;
        default: begin
          // compress, mask in the low byte of vs1
          if (v1[i]) begin
            r.vd[8*k +: 8] = e2;
            k++;
          end
        end
      endcase
    end
    if (u.op == op_cmp_eq || u.op == op_cmp_lt) begin
      r.vd_len = 4'd8;
    end else if (u.op == op_compress) begin
      r.vd_len = 4'(k);
    end else begin
      r.vd[7:0] = acc;
      r.vd_len = 4'd1;
    end
    return r;
  endfunction

  task automatic check_result(input string name, input pu2rob_t got, input pu2rob_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got tag %0d vd %h len %0d, expected tag %0d vd %h len %0d",
               $time, name, got.rob_idx, got.vd, got.vd_len,
               exp.rob_idx, exp.vd, exp.vd_len);
      $display("Testbench failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1, "control mismatch");
    end
  endtask

  task automatic make_uop(input logic [3:0] tag, output pmtrdt_uop_t u);
    logic [63:0] v1;
    logic [63:0] v2;
    int unsigned rnd;
    rnd = $random(uop_seed);
    v2 = {$random(uop_seed), $random(uop_seed)};
    v1 = {$random(uop_seed), $random(uop_seed)};
    u.rob_idx = tag;
    u.op = pmtrdt_op_e'(3'(rnd % 6));
    if (u.op == op_compress) begin
      // corner masks now and then
      if (rnd[12:11] == 2'd0) begin
        v1[7:0] = 8'h00;
      end else if (rnd[12:11] == 2'd1) begin
        v1[7:0] = 8'hff;
      end
    end else if (u.op == op_cmp_eq || u.op == op_cmp_lt) begin
      // copy some elements so eq hits
      for (int i = 0; i < 8; i++) begin
        if (rnd[16+i]) begin
          v1[8*i +: 8] = v2[8*i +: 8];
        end
      end
    end
    u.vs1 = v1;
    u.vs2 = v2;
  endtask

  // hold valid until a posedge with uop_ready
  task automatic issue_uop(input pmtrdt_uop_t u);
    uop = u;
    uop_valid = 1'b1;
    @(negedge clk);
    while (!uop_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
  endtask

  initial begin
    pmtrdt_uop_t u;
    logic [3:0]  tag;
    int unsigned rnd;
    rst = 1'b1;
    uop_valid = 1'b0;
    uop = '0;
    rob_ready = 1'b1;
    for (int i = 0; i < 16; i++) begin
      outstanding[i] = 1'b0;
      is_cpr_tag[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_ctrl("rob_valid", rob_valid, 1'b0);
    check_ctrl("uop_ready", uop_ready, 1'b1);
    @(posedge clk);
    #1;
    tag = 4'd0;
    for (int n = 0; n < num_uops; n++) begin
      // tag still in flight
      while (outstanding[tag]) begin
        @(posedge clk);
        #1;
      end
      make_uop(tag, u);
      exp_store[tag] = expected_result(u);
      is_cpr_tag[tag] = (u.op == op_compress);
      outstanding[tag] = 1'b1;
      if (u.op == op_compress) begin
        cpr_order.push_back(tag);
      end else begin
        rdt_order.push_back(tag);
      end
      issue_uop(u);
      tag = tag + 4'd1;
      rnd = $random(uop_seed);
      if (rnd[2:0] == 3'd0) begin
        @(posedge clk);
        #1;
      end
    end
    while (received != num_uops) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_ctrl("rob_valid after drain", rob_valid, 1'b0);
    check_ctrl("uop_ready dropped", saw_full, 1'b1);
    $display("Testbench passed");
    $finish;
  end

  // rob_ready in random high and low stretches
  initial begin
    int          stretch;
    int unsigned rnd;
    logic        level;
    stretch = 0;
    level = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (stretch == 0) begin
        rnd = $random(bp_seed);
        level = (rnd % 3 != 0);
        stretch = level ? 1 + int'(rnd[12:8] % 16) : 10 + int'(rnd[12:8] % 20);
      end
      rob_ready = level;
      stretch--;
    end
  end

  // sampled at negedge, transfer happens on the next posedge
  always @(negedge clk) begin : rob_monitor
    logic [3:0] front;
    if (!rst) begin
      // valid stays up through a stall
      // the round-robin grant may still move to the other unit
      if (stalled) begin
        check_ctrl("rob_valid", rob_valid, 1'b1);
      end
      if (!uop_ready) begin
        saw_full = 1'b1;
      end
      if (rob_valid && rob_ready) begin
        check_ctrl("tag outstanding", outstanding[rob_result.rob_idx], 1'b1);
        if (is_cpr_tag[rob_result.rob_idx]) begin
          front = cpr_order.pop_front();
        end else begin
          front = rdt_order.pop_front();
        end
        check_result("rob_result", rob_result, exp_store[front]);
        outstanding[front] = 1'b0;
        received++;
      end
      stalled = rob_valid && !rob_ready;
    end
  end

  initial begin
    #(timeout_ns);
    $display("Error at %0t ns: run timed out with %0d of %0d results back",
             $time, received, num_uops);
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: src.f
logic/pmtrdt_pkg.sv
logic/pmtrdt_res_if.sv
logic/pmtrdt_rs_queue.sv
logic/pmtrdt_rdt_cmp_unit.sv
logic/pmtrdt_compress_unit.sv
logic/pmtrdt_result_merge.sv
logic/pmtrdt_top.sv
tests/pmtrdt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pmtrdt testbench with Verilator
# pass or fail comes from the log, exit status follows it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module pmtrdt_tb -f src.f \
  --Mdir obj_dir -o pmtrdt_sim \
  && ./obj_dir/pmtrdt_sim 2>&1 | tee sim.log

grep -qx "Testbench passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see sim.log"; exit 1; }
